// ==== sources.f ====
source/aluPkg.sv
source/opDecode.sv
source/opQueue.sv
source/aluExecute.sv
source/barrelShifter.sv
source/aluTop.sv
test/aluCheck_sva.sv
test/aluTb.sv

// ==== Makefile ====
# Verilator build and run of the integer execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= aluTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJDIR)

// ==== test/aluTb.sv ====
// --------------------------------------------------
// Integer execute stage testbench
// Directed and random instruction streams, a
// reference model, in-order result checking with
// output back-pressure, and a watchdog
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aluTb;
   import aluPkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int MAX_INST   = 450;                    // Upper bound over all tests
   localparam int WATCHDOG_CYCLES = MAX_INST * 40 + 500;
   localparam logic [31:0] RAND_SEED = 32'h2595_df7f;
   localparam logic [OPC_W-1:0] LEGAL_OPC [11] = '{OPC_ADD, OPC_RSUB, OPC_ADDC, OPC_RSUBC,
      OPC_CMP, OPC_BSF, OPC_OR, OPC_AND, OPC_XOR, OPC_ANDN, OPC_SHIFT};

   logic clk_i, rst_i;
   logic instValid_i, instReady_o;
   logic [OPC_W-1:0]  instOpc_i;
   logic [IMM_W-1:0]  instImm_i;
   logic [DATA_W-1:0] instOpA_i, instOpB_i;
   logic resValid_o, resCarry_o, resReady_i;
   logic [DATA_W-1:0] resData_o;

   logic [DATA_W:0] expQ [$];          // {carry, data} in acceptance order
   logic [DATA_W:0] expHead;
   logic modelCarry;                   // Carry flag as the model sees it
   logic stallOn;                      // Random back-pressure enable
   int   legalSent, resultsSeen;
   int   dataErrors, carryErrors, otherErrors;

   aluTop #(.QUEUE_DEPTH(4)) DUT (
      .clk_i(clk_i), .rst_i(rst_i),
      .instValid_i(instValid_i), .instOpc_i(instOpc_i), .instImm_i(instImm_i),
      .instOpA_i(instOpA_i), .instOpB_i(instOpB_i), .instReady_o(instReady_o),
      .resValid_o(resValid_o), .resData_o(resData_o), .resCarry_o(resCarry_o),
      .resReady_i(resReady_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // Expected {legal, carry, data} straight from the operation rules
   function automatic logic [DATA_W+1:0] refModel(input logic [OPC_W-1:0] opc,
      input logic [IMM_W-1:0] imm, input logic [31:0] a, input logic [31:0] b,
      input logic c);
      logic [32:0] s;
      logic [31:0] r;
      logic nc;
      logic ok;
      r  = '0;
      nc = c;                          // Unchanged unless a rule says so
      ok = 1'b1;
      case (opc)
         OPC_ADD:   s = {1'b0, a} + {1'b0, b};
         OPC_ADDC:  s = {1'b0, a} + {1'b0, b} + 33'(c);
         OPC_RSUB:  s = {1'b0, b} + {1'b0, ~a} + 33'd1;
         OPC_RSUBC: s = {1'b0, b} + {1'b0, ~a} + 33'(c);
         default:   s = '0;
      endcase
      case (opc)
         OPC_ADD, OPC_ADDC, OPC_RSUB, OPC_RSUBC: begin
            r  = s[31:0];
            nc = s[32];
         end
         OPC_CMP: begin
            r     = b - a;
            r[31] = imm[1] ? (a > b) : ($signed(a) > $signed(b));
         end
         OPC_OR:   r = a | b;
         OPC_AND:  r = a & b;
         OPC_XOR:  r = a ^ b;
         OPC_ANDN: r = a & ~b;
         OPC_SHIFT: begin
            case (imm[6:5])
               2'd0: r = {a[31], a[31:1]};
               2'd1: r = {c, a[31:1]};
               2'd2: r = {1'b0, a[31:1]};
               default: r = imm[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
            endcase
            if (imm[6:5] != 2'd3) nc = a[0];   // Old bit 0 falls out
         end
         OPC_BSF: begin
            case (imm[10:9])
               2'd0: r = a >> b[4:0];
               2'd1: r = $signed(a) >>> b[4:0];
               2'd2: r = a << b[4:0];
               default: ok = 1'b0;
            endcase
         end
         default: ok = 1'b0;
      endcase
      return {ok, nc, r};
   endfunction

   // Random legal opcode and immediate as {opc, imm}
   function automatic logic [OPC_W+IMM_W-1:0] randLegal();
      logic [OPC_W-1:0] opc;
      logic [IMM_W-1:0] imm;
      imm = 16'($urandom);
      opc = LEGAL_OPC[$urandom % 11];
      if (opc == OPC_BSF && imm[10:9] == 2'd3) imm[10:9] = 2'($urandom % 3);
      return {opc, imm};
   endfunction

   // Present one instruction and wait for its transfer
   task automatic sendInst(input logic [OPC_W-1:0] opc, input logic [IMM_W-1:0] imm,
      input logic [31:0] a, input logic [31:0] b);
      logic [DATA_W+1:0] expVal;
      expVal = refModel(opc, imm, a, b, modelCarry);
      @(negedge clk_i);
      instValid_i = 1'b1;
      instOpc_i   = opc;
      instImm_i   = imm;
      instOpA_i   = a;
      instOpB_i   = b;
      do @(posedge clk_i); while (!instReady_o);   // Sampled before the edge updates
      if (expVal[DATA_W+1]) begin
         expQ.push_back(expVal[DATA_W:0]);
         modelCarry = expVal[DATA_W];
         legalSent++;
      end
   endtask

   task automatic idleInput(input int cycles);
      repeat (cycles) begin
         @(negedge clk_i);
         instValid_i = 1'b0;
      end
   endtask

   task automatic drainResults();
      idleInput(1);
      while (expQ.size() != 0) @(posedge clk_i);
      repeat (4) @(posedge clk_i);
   endtask

   // Result checker, one expectation per transfer
   always @(posedge clk_i) begin
      if (!rst_i && resValid_o && resReady_i) begin
         resultsSeen++;
         if (expQ.size() == 0) begin
            $display("Result at %0t ns with no instruction pending", $time);
            otherErrors++;
         end else begin
            expHead = expQ.pop_front();
            if (resData_o !== expHead[DATA_W-1:0]) begin
               $display("** Error at %0t ns: resData_o = %h, expected %h",
                        $time, resData_o, expHead[DATA_W-1:0]);
               dataErrors++;
            end
            if (resCarry_o !== expHead[DATA_W]) begin
               $display("** Error at %0t ns: resCarry_o = %b, expected %b",
                        $time, resCarry_o, expHead[DATA_W]);
               carryErrors++;
            end
         end
      end
   end

   // Output back-pressure in random stretches
   initial begin
      forever begin
         @(negedge clk_i);
         if (stallOn && ($urandom % 4 == 0)) begin
            resReady_i = 1'b0;
            repeat ($urandom % 12 + 1) @(negedge clk_i);
         end
         resReady_i = 1'b1;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

   initial begin
      logic [31:0] a, b;
      logic [OPC_W+IMM_W-1:0] pick;
      int startLegal, startSeen, errTotal;
      void'($urandom(RAND_SEED));      // Seed the generator once
      rst_i = 1'b1;
      instValid_i = 1'b0;
      instOpc_i = '0;
      instImm_i = '0;
      instOpA_i = '0;
      instOpB_i = '0;
      resReady_i = 1'b1;
      stallOn = 1'b0;
      modelCarry = 1'b0;
      legalSent = 0; resultsSeen = 0;
      dataErrors = 0; carryErrors = 0; otherErrors = 0;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      if (resValid_o !== 1'b0 || instReady_o !== 1'b1) begin
         $display("Handshake outputs not idle after reset");
         otherErrors++;
      end

      // Adds and reverse subtracts, then carry chains
      sendInst(OPC_ADD, 16'h0, 32'd5, 32'd7);
      sendInst(OPC_ADD, 16'h0, 32'hffff_ffff, 32'd2);
      sendInst(OPC_RSUB, 16'h0, 32'd3, 32'd10);
      sendInst(OPC_RSUB, 16'h0, 32'd10, 32'd3);
      sendInst(OPC_ADD, 16'h0, 32'hffff_ffff, 32'hffff_ffff);
      sendInst(OPC_ADDC, 16'h0, 32'hffff_ffff, 32'd0);
      sendInst(OPC_ADDC, 16'h0, 32'd1, 32'd1);
      sendInst(OPC_ADDC, 16'h0, 32'h8000_0000, 32'h8000_0000);
      sendInst(OPC_RSUB, 16'h0, 32'd5, 32'd2);
      sendInst(OPC_RSUBC, 16'h0, 32'd0, 32'd0);
      sendInst(OPC_RSUBC, 16'h0, 32'd0, 32'd1);
      sendInst(OPC_RSUBC, 16'h0, 32'd1, 32'd5);

      // Compares across the sign boundary, carry set first
      sendInst(OPC_ADD, 16'h0, 32'hffff_ffff, 32'd1);
      for (int i = 0; i < 2; i++) begin
         sendInst(OPC_CMP, 16'(i * 2), 32'd1, 32'hffff_ffff);
         sendInst(OPC_CMP, 16'(i * 2), 32'hffff_ffff, 32'd1);
         sendInst(OPC_CMP, 16'(i * 2), 32'h8000_0000, 32'h7fff_ffff);
         sendInst(OPC_CMP, 16'(i * 2), 32'h7fff_ffff, 32'h8000_0000);
      end

      // Logic, single shifts, sign extension
      for (int i = 0; i < 8; i++) begin
         a = $urandom;
         b = $urandom;
         sendInst(OPC_OR, 16'h0, a, b);
         sendInst(OPC_AND, 16'h0, a, b);
         sendInst(OPC_XOR, 16'h0, a, b);
         sendInst(OPC_ANDN, 16'h0, a, b);
         sendInst(OPC_SHIFT, 16'h0000, a, b);    // SRA
         sendInst(OPC_SHIFT, 16'h0020, b, a);    // SRC
         sendInst(OPC_SHIFT, 16'h0040, a, b);    // SRL
         sendInst(OPC_SHIFT, 16'h0060, a, b);    // SEXT8
         sendInst(OPC_SHIFT, 16'h0061, b, a);    // SEXT16
      end

      // Barrel shifts, every kind and amount
      for (int k = 0; k < 3; k++) begin
         for (int n = 0; n < 32; n++) begin
            b = {27'($urandom), 5'(n)};
            sendInst(OPC_BSF, 16'(k) << 9, $urandom, b);
         end
      end
      drainResults();

      // Illegal opcodes mixed in
      startLegal = legalSent;
      startSeen  = resultsSeen;
      for (int i = 0; i < 40; i++) begin
         pick = randLegal();
         case ($urandom % 4)
            0: pick[21:16] = 6'($urandom);        // Mostly unknown opcodes
            1: pick = {OPC_BSF, 16'h0600};        // Unused shift selector
            default: ;
         endcase
         sendInst(pick[21:16], pick[15:0], $urandom, $urandom);
      end
      drainResults();
      if (resultsSeen - startSeen != legalSent - startLegal) begin
         $display("Illegal mix gave %0d results for %0d legal instructions",
                  resultsSeen - startSeen, legalSent - startLegal);
         otherErrors++;
      end

      // Random streams under back-pressure
      stallOn = 1'b1;
      for (int i = 0; i < 180; i++) begin
         pick = randLegal();
         if ($urandom % 10 == 0) pick[21:16] = 6'($urandom);
         sendInst(pick[21:16], pick[15:0], $urandom, $urandom);
         if ($urandom % 8 == 0) idleInput(int'($urandom % 3) + 1);
      end
      drainResults();
      stallOn = 1'b0;

      if (resultsSeen != legalSent) begin
         $display("Result count %0d does not match %0d legal instructions",
                  resultsSeen, legalSent);
         otherErrors++;
      end
      errTotal = dataErrors + carryErrors + otherErrors;
      $display("Results %0d of %0d, data mismatches %0d, carry mismatches %0d, other %0d",
               resultsSeen, legalSent, dataErrors, carryErrors, otherErrors);
      if (errTotal == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/aluCheck_sva.sv ====
// --------------------------------------------------
// Execute stage handshake assertions
// Held results stay stable and the output stream
// is idle right after reset
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aluCheck (
   input logic                        clk_i,
   input logic                        rst_i,
   input logic                        instReady_i,
   input logic                        resValid_i,
   input logic [aluPkg::DATA_W-1:0]   resData_i,
   input logic                        resCarry_i,
   input logic                        resReady_i
);

   // Stalled result keeps valid, data and carry
   holdStable: assert property (@(posedge clk_i) disable iff (rst_i)
      resValid_i && !resReady_i |=> resValid_i && $stable(resData_i) && $stable(resCarry_i))
      else $error("Result or carry changed while held");

   resetIdle: assert property (@(posedge clk_i) rst_i |=> !resValid_i)
      else $error("resValid_o high after reset");

   resetReady: assert property (@(posedge clk_i) rst_i |=> instReady_i)
      else $error("instReady_o low after reset");

endmodule

bind aluTop aluCheck uCheck (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .instReady_i (instReady_o),
   .resValid_i  (resValid_o),
   .resData_i   (resData_o),
   .resCarry_i  (resCarry_o),
   .resReady_i  (resReady_i)
);

`default_nettype wire

// ==== source/aluTop.sv ====
// --------------------------------------------------
// Integer execute stage
// Decoder, operation queue, execute unit and
// barrel shifter behind valid/ready streams
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aluTop #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        instValid_i,
   input  logic [aluPkg::OPC_W-1:0]    instOpc_i,
   input  logic [aluPkg::IMM_W-1:0]    instImm_i,
   input  logic [aluPkg::DATA_W-1:0]   instOpA_i,
   input  logic [aluPkg::DATA_W-1:0]   instOpB_i,
   output logic                        instReady_o,
   output logic                        resValid_o,
   output logic [aluPkg::DATA_W-1:0]   resData_o,
   output logic                        resCarry_o,
   input  logic                        resReady_i
);
   import aluPkg::*;

   // Decoder to queue
   logic              decValid, decReady;
   aluOp_e            decOp;
   logic [DATA_W-1:0] decOpA, decOpB;

   // Queue to execute
   logic              qValid, qReady;
   aluOp_e            qOp;
   logic [DATA_W-1:0] qOpA, qOpB;

   // Execute to shifter
   shiftSel_e         bsfKind;
   logic [DATA_W-1:0] bsfResult;

   opDecode uDecode (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .instValid_i (instValid_i),
      .instOpc_i   (instOpc_i),
      .instImm_i   (instImm_i),
      .instOpA_i   (instOpA_i),
      .instOpB_i   (instOpB_i),
      .instReady_o (instReady_o),
      .decValid_o  (decValid),
      .decOp_o     (decOp),
      .decOpA_o    (decOpA),
      .decOpB_o    (decOpB),
      .decReady_i  (decReady)
   );

   opQueue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) uQueue (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wrValid_i (decValid),
      .wrOp_i    (decOp),
      .wrOpA_i   (decOpA),
      .wrOpB_i   (decOpB),
      .wrReady_o (decReady),
      .rdValid_o (qValid),
      .rdOp_o    (qOp),
      .rdOpA_o   (qOpA),
      .rdOpB_o   (qOpB),
      .rdReady_i (qReady)
   );

   aluExecute uExecute (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .opValid_i   (qValid),
      .op_i        (qOp),
      .opA_i       (qOpA),
      .opB_i       (qOpB),
      .opReady_o   (qReady),
      .bsfKind_o   (bsfKind),
      .bsfResult_i (bsfResult),
      .resValid_o  (resValid_o),
      .resData_o   (resData_o),
      .resCarry_o  (resCarry_o),
      .resReady_i  (resReady_i)
   );

   // Shift amount comes from the low bits of B
   barrelShifter uShifter (
      .shiftKind_i (bsfKind),
      .value_i     (qOpA),
      .amount_i    (qOpB[4:0]),
      .result_o    (bsfResult)
   );

endmodule

`default_nettype wire

// ==== source/barrelShifter.sv ====
// --------------------------------------------------
// Barrel shifter
// Logical right, arithmetic right and left shift by
// a five-bit amount, built from log-step mux stages
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module barrelShifter (
   input  aluPkg::shiftSel_e           shiftKind_i,
   input  logic [aluPkg::DATA_W-1:0]   value_i,
   input  logic [4:0]                  amount_i,
   output logic [aluPkg::DATA_W-1:0]   result_o
);
   import aluPkg::*;

   localparam int STAGES = 5;          // One per amount bit

   logic [DATA_W-1:0] srlStep [STAGES+1];
   logic [DATA_W-1:0] sraStep [STAGES+1];
   logic [DATA_W-1:0] sllStep [STAGES+1];

   assign srlStep[0] = value_i;
   assign sraStep[0] = value_i;
   assign sllStep[0] = value_i;

   // Stage k shifts by 2**k when amount bit k is set
   for (genvar k = 0; k < STAGES; k++) begin : gStage
      assign srlStep[k+1] = amount_i[k] ? (srlStep[k] >> (2**k)) : srlStep[k];
      assign sraStep[k+1] = amount_i[k] ? $unsigned($signed(sraStep[k]) >>> (2**k))
                                        : sraStep[k];   // Sign fill kept inside
      assign sllStep[k+1] = amount_i[k] ? (sllStep[k] << (2**k)) : sllStep[k];
   end

   always_comb begin
      case (shiftKind_i)
         BSF_SRA: result_o = sraStep[STAGES];
         BSF_SLL: result_o = sllStep[STAGES];
         default: result_o = srlStep[STAGES];   // Logical right
      endcase
   end

endmodule

`default_nettype wire

// ==== source/aluExecute.sv ====
// --------------------------------------------------
// Execute unit
// Shared adder, compare, logic, one-bit shifts and
// sign extension; holds the carry flag and the
// registered result with its output handshake
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        opValid_i,
   input  aluPkg::aluOp_e              op_i,
   input  logic [aluPkg::DATA_W-1:0]   opA_i,
   input  logic [aluPkg::DATA_W-1:0]   opB_i,
   output logic                        opReady_o,
   output aluPkg::shiftSel_e           bsfKind_o,
   input  logic [aluPkg::DATA_W-1:0]   bsfResult_i,
   output logic                        resValid_o,
   output logic [aluPkg::DATA_W-1:0]   resData_o,
   output logic                        resCarry_o,
   input  logic                        resReady_i
);
   import aluPkg::*;

   logic              opTake;
   logic              invA;            // Reverse subtract and compare
   logic              carryIn;
   logic [DATA_W-1:0] addA;
   logic [DATA_W:0]   sum;             // Bit DATA_W is carry-out
   logic              cmpGt;           // A greater than B
   logic [DATA_W-1:0] resNext;
   logic              carryNext;

   // Output register free, or being emptied now
   assign opReady_o = ~resValid_o | resReady_i;
   assign opTake    = opValid_i & opReady_o;

   always_comb begin
      case (op_i)
         OP_RSUB, OP_RSUBC, OP_CMP, OP_CMPU: invA = 1'b1;
         default:                            invA = 1'b0;
      endcase
      case (op_i)
         OP_ADDC, OP_RSUBC:         carryIn = resCarry_o;   // Chain through stored carry
         OP_RSUB, OP_CMP, OP_CMPU:  carryIn = 1'b1;         // Two's complement
         default:                   carryIn = 1'b0;
      endcase
   end

   assign addA = invA ? ~opA_i : opA_i;
   assign sum  = {1'b0, opB_i} + {1'b0, addA} + {{DATA_W{1'b0}}, carryIn};

   assign cmpGt = (op_i == OP_CMPU) ? (opA_i > opB_i)
                                    : ($signed(opA_i) > $signed(opB_i));

   // Barrel shift kind for the neighbouring shifter
   always_comb begin
      case (op_i)
         OP_BSRA: bsfKind_o = BSF_SRA;
         OP_BSLL: bsfKind_o = BSF_SLL;
         default: bsfKind_o = BSF_SRL;
      endcase
   end

   // Result and carry select
   always_comb begin
      resNext   = sum[DATA_W-1:0];
      carryNext = resCarry_o;          // Most ops keep it
      case (op_i)
         OP_ADD, OP_ADDC, OP_RSUB, OP_RSUBC: begin
            carryNext = sum[DATA_W];
         end
         OP_CMP, OP_CMPU: begin
            resNext = {cmpGt, sum[DATA_W-2:0]};   // MSB carries the flag
         end
         OP_OR:   resNext = opA_i | opB_i;
         OP_AND:  resNext = opA_i & opB_i;
         OP_XOR:  resNext = opA_i ^ opB_i;
         OP_ANDN: resNext = opA_i & ~opB_i;
         OP_SRA: begin
            resNext   = {opA_i[DATA_W-1], opA_i[DATA_W-1:1]};
            carryNext = opA_i[0];
         end
         OP_SRC: begin
            resNext   = {resCarry_o, opA_i[DATA_W-1:1]};  // Rotate through carry
            carryNext = opA_i[0];
         end
         OP_SRL: begin
            resNext   = {1'b0, opA_i[DATA_W-1:1]};
            carryNext = opA_i[0];
         end
         OP_SEXT8:  resNext = {{(DATA_W-8){opA_i[7]}}, opA_i[7:0]};
         OP_SEXT16: resNext = {{(DATA_W-16){opA_i[15]}}, opA_i[15:0]};
         OP_BSRL, OP_BSRA, OP_BSLL: resNext = bsfResult_i;
         default: resNext = sum[DATA_W-1:0];
      endcase
   end

   // Control and carry flag
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         resValid_o <= 1'b0;
         resCarry_o <= 1'b0;
      end else if (opTake) begin
         resValid_o <= 1'b1;
         resCarry_o <= carryNext;      // Updated only when a result is taken in
      end else if (resReady_i) begin
         resValid_o <= 1'b0;
      end
   end

   // Result data
   always_ff @(posedge clk_i) begin
      if (opTake) resData_o <= resNext;
   end

endmodule

`default_nettype wire

// ==== source/opQueue.sv ====
// --------------------------------------------------
// Operation queue
// Circular buffer of decoded operations between
// decoder and execute unit, no fall-through
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module opQueue #(
   parameter int QUEUE_DEPTH = 4       // Power of two, 2 or more
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        wrValid_i,
   input  aluPkg::aluOp_e              wrOp_i,
   input  logic [aluPkg::DATA_W-1:0]   wrOpA_i,
   input  logic [aluPkg::DATA_W-1:0]   wrOpB_i,
   output logic                        wrReady_o,
   output logic                        rdValid_o,
   output aluPkg::aluOp_e              rdOp_o,
   output logic [aluPkg::DATA_W-1:0]   rdOpA_o,
   output logic [aluPkg::DATA_W-1:0]   rdOpB_o,
   input  logic                        rdReady_i
);
   import aluPkg::*;

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = PTR_W + 1;
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

   aluOp_e            opMem  [QUEUE_DEPTH];
   logic [DATA_W-1:0] opAMem [QUEUE_DEPTH];
   logic [DATA_W-1:0] opBMem [QUEUE_DEPTH];

   logic [PTR_W-1:0] wrPtr, rdPtr;     // Wrap on their own width
   logic [CNT_W-1:0] count;            // Occupancy
   logic             wrEn, rdEn;

   assign rdValid_o = (count != '0);
   assign wrReady_o = (count != FULL_CNT) | rdReady_i;   // Full, but head leaves
   assign wrEn      = wrValid_i & wrReady_o;
   assign rdEn      = rdValid_o & rdReady_i;

   // Head of queue
   assign rdOp_o  = opMem[rdPtr];
   assign rdOpA_o = opAMem[rdPtr];
   assign rdOpB_o = opBMem[rdPtr];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (wrEn) wrPtr <= wrPtr + 1'b1;
         if (rdEn) rdPtr <= rdPtr + 1'b1;
         case ({wrEn, rdEn})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // Both or neither
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (wrEn) begin
         opMem[wrPtr]  <= wrOp_i;
         opAMem[wrPtr] <= wrOpA_i;
         opBMem[wrPtr] <= wrOpB_i;
      end
   end

endmodule

`default_nettype wire

// ==== source/opDecode.sv ====
// --------------------------------------------------
// Instruction decoder
// Maps raw opcode and immediate bits onto one
// operation code, registered with the operands
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module opDecode (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        instValid_i,
   input  logic [aluPkg::OPC_W-1:0]    instOpc_i,
   input  logic [aluPkg::IMM_W-1:0]    instImm_i,
   input  logic [aluPkg::DATA_W-1:0]   instOpA_i,
   input  logic [aluPkg::DATA_W-1:0]   instOpB_i,
   output logic                        instReady_o,
   output logic                        decValid_o,
   output aluPkg::aluOp_e              decOp_o,
   output logic [aluPkg::DATA_W-1:0]   decOpA_o,
   output logic [aluPkg::DATA_W-1:0]   decOpB_o,
   input  logic                        decReady_i
);
   import aluPkg::*;

   aluOp_e opNext;     // Classified operation
   logic   opLegal;    // Known opcode and selector
   logic   instTake;   // Input transfer this cycle

   // Free slot when empty or the queue takes the held entry
   assign instReady_o = ~decValid_o | decReady_i;
   assign instTake    = instValid_i & instReady_o;

   always_comb begin
      opNext  = OP_ADD;
      opLegal = 1'b1;
      case (instOpc_i)
         OPC_ADD:   opNext = OP_ADD;
         OPC_RSUB:  opNext = OP_RSUB;
         OPC_ADDC:  opNext = OP_ADDC;
         OPC_RSUBC: opNext = OP_RSUBC;
         OPC_CMP:   opNext = instImm_i[1] ? OP_CMPU : OP_CMP;
         OPC_OR:    opNext = OP_OR;
         OPC_AND:   opNext = OP_AND;
         OPC_XOR:   opNext = OP_XOR;
         OPC_ANDN:  opNext = OP_ANDN;
         OPC_BSF: begin
            case (instImm_i[10:9])
               2'd0:    opNext = OP_BSRL;
               2'd1:    opNext = OP_BSRA;
               2'd2:    opNext = OP_BSLL;
               default: opLegal = 1'b0;   // Selector 3 unused
            endcase
         end
         OPC_SHIFT: begin
            case (instImm_i[6:5])
               2'd0:    opNext = OP_SRA;
               2'd1:    opNext = OP_SRC;
               2'd2:    opNext = OP_SRL;
               default: opNext = instImm_i[0] ? OP_SEXT16 : OP_SEXT8;
            endcase
         end
         default: opLegal = 1'b0;         // Swallowed, no output
      endcase
   end

   // Valid flag
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         decValid_o <= 1'b0;
      end else if (instTake) begin
         decValid_o <= opLegal;           // Illegal ones leave the slot empty
      end else if (decReady_i) begin
         decValid_o <= 1'b0;              // Entry handed to the queue
      end
   end

   // Payload
   always_ff @(posedge clk_i) begin
      if (instTake) begin
         decOp_o  <= opNext;
         decOpA_o <= instOpA_i;
         decOpB_o <= instOpB_i;
      end
   end

endmodule

`default_nettype wire

// ==== source/aluPkg.sv ====
// --------------------------------------------------
// ALU shared definitions
// Data widths, raw opcode values of the instruction
// set and the decoded operation encodings
// --------------------------------------------------
`default_nettype none

package aluPkg;

   localparam int DATA_W = 32;   // Operand and result width
   localparam int IMM_W  = 16;   // Immediate field
   localparam int OPC_W  = 6;    // Raw opcode field

   // Raw opcodes, adder group
   localparam logic [OPC_W-1:0] OPC_ADD   = 6'o00;
   localparam logic [OPC_W-1:0] OPC_RSUB  = 6'o01;
   localparam logic [OPC_W-1:0] OPC_ADDC  = 6'o02;
   localparam logic [OPC_W-1:0] OPC_RSUBC = 6'o03;
   localparam logic [OPC_W-1:0] OPC_CMP   = 6'o05;  // imm[1] selects unsigned
   localparam logic [OPC_W-1:0] OPC_BSF   = 6'o21;  // imm[10:9] selects shift kind

   // Logic group
   localparam logic [OPC_W-1:0] OPC_OR    = 6'o40;
   localparam logic [OPC_W-1:0] OPC_AND   = 6'o41;
   localparam logic [OPC_W-1:0] OPC_XOR   = 6'o42;
   localparam logic [OPC_W-1:0] OPC_ANDN  = 6'o43;
   localparam logic [OPC_W-1:0] OPC_SHIFT = 6'o44;  // imm[6:5] kind, imm[0] sext width

   // Decoded operations
   typedef enum logic [4:0] {
      OP_ADD, OP_ADDC, OP_RSUB, OP_RSUBC,
      OP_CMP, OP_CMPU,
      OP_OR, OP_AND, OP_XOR, OP_ANDN,
      OP_SRA, OP_SRC, OP_SRL,
      OP_SEXT8, OP_SEXT16,
      OP_BSRL, OP_BSRA, OP_BSLL
   } aluOp_e;

   // Barrel shift kind, same order as imm[10:9]
   typedef enum logic [1:0] {
      BSF_SRL,
      BSF_SRA,
      BSF_SLL
   } shiftSel_e;

endpackage

`default_nettype wire
